// File: src/ps2_kbd_pkg.sv
/*
 * PS/2 keyboard controller package
 * Design constants, scan codes, the receiver event, the status word,
 * the Wishbone request bundle and the state and register enums.
 */
`default_nettype none

package ps2_kbd_pkg;

    localparam logic [15:0] rx_timeout_cycles = 16'd2000;  // Stall limit in system cycles

    localparam logic [7:0] code_break_prefix = 8'hF0;
    localparam logic [7:0] code_ack          = 8'hFA;
    localparam logic [7:0] code_error        = 8'hFF;
    localparam logic [7:0] code_f11          = 8'h78;      // Video swap hotkey
    localparam logic [7:0] code_f12          = 8'h07;      // Pause hotkey
    localparam logic [7:0] code_f7_ext       = 8'h83;

    localparam string xlat_file = "set2_to_set1.hex";     // Set 2 to set 1 table, 00 to 7F

    typedef struct packed {
        logic       valid;
        logic       error;
        logic [7:0] data;
    } rx_event_t;

    typedef struct packed {
        logic       irq;
        logic       pause_core;
        logic       swap_video;
        logic [7:0] keycode;
    } kbd_status_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic       adr;
        logic [7:0] dat;
    } wb_req_t;

    typedef enum logic {rx_idle, rx_shift} rx_state_e;

    typedef enum logic {reg_keycode = 1'b0, reg_status = 1'b1} reg_sel_e;

endpackage

`default_nettype wire

// File: src/ps2_rx_shifter.sv
/*
 * PS/2 frame receiver
 * Synchronizes the device clock and data lines, shifts in 11-bit frames
 * on falling clock edges and checks start, odd parity and stop.
 * A frame that stalls part-way is dropped with an error event.
 */
`timescale 1ns/100ps
`default_nettype none

module ps2_rx_shifter (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    device_clock,
    input  logic                    device_data,
    output ps2_kbd_pkg::rx_event_t  rx_event
);
    import ps2_kbd_pkg::*;

    logic [2:0]  clock_sync;   // Two sync stages plus previous value
    logic [1:0]  data_sync;
    logic        fall_edge;
    logic        edge_data;
    rx_state_e   state;
    logic [3:0]  bit_count;
    logic [15:0] idle_timer;
    logic [10:0] shift_reg;
    logic [10:0] next_frame;
    logic        frame_ok;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            clock_sync <= 3'b111;  // Lines idle high
            data_sync  <= 2'b11;
            fall_edge  <= 1'b0;
            edge_data  <= 1'b1;
        end else begin
            clock_sync <= {clock_sync[1:0], device_clock};
            data_sync  <= {data_sync[0], device_data};
            fall_edge  <= clock_sync[2] & ~clock_sync[1];
            edge_data  <= data_sync[1];
        end
    end

    // Frame as it stands once the current bit is in
    always_comb begin
        next_frame = {edge_data, shift_reg[10:1]};
        frame_ok   = (next_frame[0] == 1'b0) && (^next_frame[9:1]) && next_frame[10];
    end

    always_ff @(posedge clock) begin
        if (fall_edge) begin
            shift_reg <= next_frame;  // LSB first
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= rx_idle;
            bit_count  <= 4'd0;
            idle_timer <= 16'd0;
            rx_event   <= '0;
        end else begin
            rx_event.valid <= 1'b0;
            case (state)
                rx_idle: begin
                    if (fall_edge) begin
                        state      <= rx_shift;
                        bit_count  <= 4'd1;
                        idle_timer <= 16'd0;
                    end
                end
                rx_shift: begin
                    if (fall_edge) begin
                        idle_timer <= 16'd0;
                        if (bit_count == 4'd10) begin
                            // Stop bit is in, hand the byte over
                            state          <= rx_idle;
                            bit_count      <= 4'd0;
                            rx_event.valid <= 1'b1;
                            rx_event.error <= ~frame_ok;
                            rx_event.data  <= next_frame[8:1];
                        end else begin
                            bit_count <= bit_count + 4'd1;
                        end
                    end else if (idle_timer == rx_timeout_cycles - 16'd1) begin
                        // Keyboard went quiet mid-frame
                        state          <= rx_idle;
                        bit_count      <= 4'd0;
                        idle_timer     <= 16'd0;
                        rx_event.valid <= 1'b1;
                        rx_event.error <= 1'b1;
                    end else begin
                        idle_timer <= idle_timer + 16'd1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/keycode_mapper.sv
/*
 * Keycode mapper
 * Turns received set 2 bytes into set 1 keycodes with the break bit,
 * drops keyboard ACKs, handles the F11 and F12 release hotkeys and
 * flags errors and overruns with code FF. Holds the keycode and irq
 * until the host reads them.
 */
`timescale 1ns/100ps
`default_nettype none

module keycode_mapper (
    input  logic                      clock,
    input  logic                      reset,
    input  ps2_kbd_pkg::rx_event_t    rx_event,
    input  logic                      clear_keycode,
    output ps2_kbd_pkg::kbd_status_t  status
);
    import ps2_kbd_pkg::*;

    logic [7:0] xlat_table [0:127];
    logic [7:0] translated;
    logic       break_flag;

    initial begin
        $readmemh(xlat_file, xlat_table);
    end

    always_comb begin
        if (rx_event.data < 8'h80) begin
            translated = xlat_table[rx_event.data[6:0]];
        end else if (rx_event.data == code_f7_ext) begin
            translated = 8'h41;  // F7 sits outside the table
        end else begin
            translated = rx_event.data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            status     <= '0;
            break_flag <= 1'b0;
        end else if (clear_keycode) begin
            // Host read wins over a same-cycle event
            status.irq     <= 1'b0;
            status.keycode <= 8'h00;
            break_flag     <= 1'b0;
        end else if (rx_event.valid) begin
            if (rx_event.error || status.irq) begin
                // Bad frame, or previous code not read yet
                status.irq     <= 1'b1;
                status.keycode <= code_error;
                break_flag     <= 1'b0;
            end else if (rx_event.data == code_ack) begin
                // Keyboard ACK carries no key
            end else if (rx_event.data == code_break_prefix) begin
                break_flag <= 1'b1;
            end else if (rx_event.data == code_f11) begin
                if (break_flag) begin
                    status.swap_video <= ~status.swap_video;
                end
                break_flag <= 1'b0;
            end else if (rx_event.data == code_f12) begin
                if (break_flag) begin
                    status.pause_core <= ~status.pause_core;
                end
                break_flag <= 1'b0;
            end else if (status.pause_core) begin
                break_flag <= 1'b0;  // Keys swallowed while paused
            end else begin
                status.irq     <= 1'b1;
                status.keycode <= translated | {break_flag, 7'h00};
                break_flag     <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/kbd_wb_regs.sv
/*
 * Wishbone register port
 * Classic single-cycle slave. Address 0 reads the keycode and clears it,
 * address 1 reads irq, pause and video swap. Writes are acknowledged
 * and dropped.
 */
`timescale 1ns/100ps
`default_nettype none

module kbd_wb_regs (
    input  logic                      clock,
    input  logic                      reset,
    input  ps2_kbd_pkg::wb_req_t      wb_req,
    output logic                      wb_ack,
    output logic [7:0]                wb_dat,
    input  ps2_kbd_pkg::kbd_status_t  status,
    output logic                      clear_keycode
);
    import ps2_kbd_pkg::*;

    logic     request;
    reg_sel_e reg_sel;

    always_comb begin
        request = wb_req.cyc & wb_req.stb & ~wb_ack;  // No back-to-back ack
        reg_sel = reg_sel_e'(wb_req.adr);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_ack        <= 1'b0;
            clear_keycode <= 1'b0;
        end else begin
            wb_ack        <= request;
            clear_keycode <= request & ~wb_req.we & (reg_sel == reg_keycode);
        end
    end

    always_ff @(posedge clock) begin
        if (request && !wb_req.we) begin
            case (reg_sel)
                reg_keycode: wb_dat <= status.keycode;
                reg_status:  wb_dat <= {5'b00000, status.swap_video,
                                        status.pause_core, status.irq};
                default:     wb_dat <= 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/ps2_kbd_top.sv
/*
 * PS/2 keyboard controller top level
 * Receiver, keycode mapper and Wishbone register port in a chain.
 */
`timescale 1ns/100ps
`default_nettype none

module ps2_kbd_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  device_clock,
    input  logic                  device_data,
    input  ps2_kbd_pkg::wb_req_t  wb_req,
    output logic                  wb_ack,
    output logic [7:0]            wb_dat,
    output logic                  irq,
    output logic                  pause_core,
    output logic                  swap_video
);
    import ps2_kbd_pkg::*;

    rx_event_t   rx_event;
    kbd_status_t status;
    logic        clear_keycode;

    ps2_rx_shifter u_ps2_rx_shifter (
        .clock        (clock),
        .reset        (reset),
        .device_clock (device_clock),
        .device_data  (device_data),
        .rx_event     (rx_event)
    );

    keycode_mapper u_keycode_mapper (
        .clock         (clock),
        .reset         (reset),
        .rx_event      (rx_event),
        .clear_keycode (clear_keycode),
        .status        (status)
    );

    kbd_wb_regs u_kbd_wb_regs (
        .clock         (clock),
        .reset         (reset),
        .wb_req        (wb_req),
        .wb_ack        (wb_ack),
        .wb_dat        (wb_dat),
        .status        (status),
        .clear_keycode (clear_keycode)
    );

    assign irq        = status.irq;
    assign pause_core = status.pause_core;
    assign swap_video = status.swap_video;

endmodule

`default_nettype wire

// File: sim/ps2_kbd_properties.sv
/*
 * PS/2 keyboard controller checks
 * Wishbone ack follows a request and never repeats in the next cycle.
 * irq, ack and pause stay low while reset is held.
 */
`timescale 1ns/100ps
`default_nettype none

module ps2_kbd_properties (
    input logic                  clock,
    input logic                  reset,
    input ps2_kbd_pkg::wb_req_t  wb_req,
    input logic                  wb_ack,
    input logic                  irq,
    input logic                  pause_core
);

    ack_after_request: assert property (@(posedge clock) disable iff (reset)
        wb_ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("wb_ack raised without a request in the previous cycle");

    ack_single_cycle: assert property (@(posedge clock) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high in two consecutive cycles");

    quiet_in_reset: assert property (@(posedge clock)
        reset |-> (!irq && !wb_ack && !pause_core))
        else $error("irq, wb_ack or pause_core high during reset");

endmodule

`default_nettype wire

// File: sim/tb_ps2_kbd.sv
/*
 * Testbench for the PS/2 keyboard controller
 * Plays PS/2 frames into the top level, reads keycode and status over
 * Wishbone and compares them with a reference model of the mapper.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_ps2_kbd;
    import ps2_kbd_pkg::*;

    localparam int    half_period     = 20;  // Device half-period in system cycles
    localparam int    frame_count     = 58;
    localparam int    stall_cycles    = 2000;
    localparam int    watchdog_cycles = 2 * (frame_count * 22 * half_period + stall_cycles);
    localparam string table_file      = "set2_to_set1.hex";

    logic       clock;
    logic       reset;
    logic       device_clock;
    logic       device_data;
    wb_req_t    wb_req;
    logic       wb_ack;
    logic [7:0] wb_dat;
    logic       irq;
    logic       pause_core;
    logic       swap_video;

    logic [7:0] ref_table [0:127];
    logic       model_irq;
    logic       model_pause;
    logic       model_swap;
    logic       model_break;
    logic [7:0] model_key;
    logic [7:0] exp_dat;    // Expected data of the read in flight
    string      test_name;
    int         error_count;
    logic [7:0] code;

    ps2_kbd_top u_ps2_kbd_top (
        .clock        (clock),
        .reset        (reset),
        .device_clock (device_clock),
        .device_data  (device_data),
        .wb_req       (wb_req),
        .wb_ack       (wb_ack),
        .wb_dat       (wb_dat),
        .irq          (irq),
        .pause_core   (pause_core),
        .swap_video   (swap_video)
    );

    bind ps2_kbd_top ps2_kbd_properties u_ps2_kbd_properties (
        .clock      (clock),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_ack     (wb_ack),
        .irq        (irq),
        .pause_core (pause_core)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    // Read data is stable in the middle of the ack cycle
    always @(negedge clock) begin
        if (wb_ack) begin
            check_value(test_name, exp_dat, wb_dat);
        end
    end

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clock);
        #1;
    endtask

    function automatic logic [7:0] expected_keycode(input logic [7:0] code_in, input logic brk);
        logic [7:0] base;
        if (code_in < 8'h80) begin
            base = ref_table[code_in[6:0]];
        end else if (code_in == 8'h83) begin
            base = 8'h41;  // F7
        end else begin
            base = code_in;
        end
        return base | {brk, 7'h00};
    endfunction

    // Mapper rules in priority order
    task automatic model_event(input logic [7:0] code_in, input logic err);
        if (err || model_irq) begin
            model_irq   = 1'b1;
            model_key   = 8'hFF;
            model_break = 1'b0;
        end else if (code_in == 8'hF0) begin
            model_break = 1'b1;
        end else if (code_in == 8'h78) begin
            model_swap  = model_swap ^ model_break;
            model_break = 1'b0;
        end else if (code_in == 8'h07) begin
            model_pause = model_pause ^ model_break;
            model_break = 1'b0;
        end else if (code_in != 8'hFA) begin
            if (!model_pause) begin
                model_irq = 1'b1;
                model_key = expected_keycode(code_in, model_break);
            end
            model_break = 1'b0;
        end
    endtask

    // Start, data LSB first, odd parity, stop; nbits cuts the frame short
    task automatic send_frame(input logic [7:0] code_in, input logic bad_parity, input int nbits);
        logic [10:0] frame;
        int          i;
        frame = {1'b1, (~^code_in) ^ bad_parity, code_in, 1'b0};
        for (i = 0; i < nbits; i++) begin
            device_data = frame[i];
            wait_cycles(half_period);
            device_clock = 1'b0;
            wait_cycles(half_period);
            device_clock = 1'b1;
        end
        device_data = 1'b1;
        wait_cycles(half_period);
    endtask

    task automatic wait_irq(input string name, input int limit);
        int waited;
        waited = 0;
        while (!irq && waited < limit) begin
            wait_cycles(1);
            waited++;
        end
        if (!irq) begin
            error_count++;
            $display("%s: irq did not rise within %0d cycles", name, limit);
        end
    endtask

    task automatic wb_read(input logic adr, input logic [7:0] expected, input string name);
        int waited;
        exp_dat    = expected;
        test_name  = name;
        wb_req.adr = adr;
        wb_req.we  = 1'b0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        waited     = 0;
        do begin
            wait_cycles(1);
            waited++;
        end while (!wb_ack && waited < 8);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        if (!wb_ack) begin
            error_count++;
            $display("%s: no Wishbone ack within 8 cycles", name);
        end
        wait_cycles(1);
    endtask

    task automatic check_flags(input string name);
        check_value(name, {5'b00000, model_swap, model_pause, model_irq},
                    {5'b00000, swap_video, pause_core, irq});
    endtask

    task automatic send_key(input logic [7:0] code_in, input string name);
        send_frame(code_in, 1'b0, 11);
        model_event(code_in, 1'b0);
        if (model_irq) begin
            wait_irq(name, 16);
        end
        check_flags(name);
    endtask

    task automatic read_keycode(input string name);
        wb_read(1'b0, model_key, name);
        model_irq   = 1'b0;  // Read clears keycode and irq
        model_key   = 8'h00;
        model_break = 1'b0;
    endtask

    task automatic read_status(input string name);
        wb_read(1'b1, {5'b00000, model_swap, model_pause, model_irq}, name);
    endtask

    initial begin
        reset        = 1'b1;
        device_clock = 1'b1;
        device_data  = 1'b1;
        wb_req       = '0;
        error_count  = 0;
        model_irq    = 1'b0;
        model_pause  = 1'b0;
        model_swap   = 1'b0;
        model_break  = 1'b0;
        model_key    = 8'h00;
        exp_dat      = 8'h00;
        test_name    = "idle";
        void'($urandom(32'h639f));
        $readmemh(table_file, ref_table);
        wait_cycles(5);
        reset = 1'b0;
        wait_cycles(2);
        check_flags("reset");
        read_keycode("reset");

        repeat (40) begin
            code = 8'($urandom % 128);
            while (code == 8'h07 || code == 8'h78) begin
                code = 8'($urandom % 128);
            end
            send_key(code, "make");
            read_keycode("make");
            read_status("make status");
        end

        send_key(8'hF0, "break");
        send_key(8'h1C, "break");
        read_keycode("break");
        send_key(8'h83, "f7");
        read_keycode("f7");
        send_key(8'hFA, "keyboard ack");
        read_status("keyboard ack");

        send_frame(8'h1C, 1'b1, 11);  // Parity flipped
        model_event(8'h00, 1'b1);
        wait_irq("parity error", 16);
        read_keycode("parity error");
        send_frame(8'h2A, 1'b0, 5);   // Keyboard stalls mid-frame
        model_event(8'h00, 1'b1);
        wait_irq("stall", stall_cycles + 200);
        read_keycode("stall");
        send_key(8'h1C, "after stall");
        read_keycode("after stall");

        send_key(8'h15, "overrun");
        send_key(8'h1D, "overrun");
        read_keycode("overrun");

        send_key(8'hF0, "pause on");
        send_key(8'h07, "pause on");
        send_key(8'h1C, "paused make");
        read_status("paused make");
        send_key(8'hF0, "pause off");
        send_key(8'h07, "pause off");
        send_key(8'hF0, "swap");
        send_key(8'h78, "swap");
        send_key(8'h07, "f12 press");
        send_key(8'h78, "f11 press");
        read_status("hotkeys");

        $display("Run complete with %0d errors", error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/set2_to_set1.hex
// Set 1 keycode for each set 2 code from 00 to 7F, one byte per line
FF
43
41
3F
3D
3B
3C
58
64
44
42
40
3E
0F
29
59
65
38
2A
70
1D
10
02
5A
66
71
2C
1F
1E
11
03
5B
67
2E
2D
20
12
05
04
5C
68
39
2F
21
14
13
06
5D
69
31
30
23
22
15
07
5E
6A
72
32
24
16
08
09
5F
6B
33
25
17
18
0B
0A
60
6C
34
35
26
27
19
0C
61
6D
73
28
74
1A
0D
62
6E
3A
36
1C
1B
75
2B
63
76
55
56
77
78
79
7A
0E
7B
7C
4F
7D
4B
47
7E
7F
6F
52
53
50
4C
4D
48
01
45
57
4E
51
4A
37
49
46
54

// File: flist.f
src/ps2_kbd_pkg.sv
src/ps2_rx_shifter.sv
src/keycode_mapper.sv
src/kbd_wb_regs.sv
src/ps2_kbd_top.sv
sim/ps2_kbd_properties.sv
sim/tb_ps2_kbd.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PS/2 keyboard controller testbench with Verilator
set -e
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_ps2_kbd -f flist.f
# The translation table is loaded from the working directory
status=0
(cd src && ../obj_dir/Vtb_ps2_kbd) > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
